//--- project.f
source/line_code_pkg.sv
source/enc_8b10b.sv
source/dec_8b10b.sv
source/link_err_counter.sv
source/link_8b10b.sv
test/tb_link_8b10b.sv

//--- source/dec_8b10b.sv
// 8b/10b decoder
// Inverts both sub-block tables, recognises the twelve K codes
// Flags unused groups and groups whose sign breaks the running disparity
`timescale 1ns/1ps
`default_nettype none

module dec_8b10b import line_code_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          en,                          // Symbol present this cycle
    input  wire symbol_t symbol,
    output rx_word_t     word,
    output logic         valid
);

    symbol_t    rev;                                  // abcdeifghj with a at the MSB
    logic [5:0] g6;
    logic [3:0] g4;
    logic [3:0] g4_dec;
    logic [4:0] x5;
    logic [2:0] y3;
    logic [2:0] ones6;
    logic [2:0] ones4;
    logic       ok6;
    logic       ok4;
    logic       k28;
    logic       k_alt;
    logic       rd;                                   // Running disparity with 1 as positive
    logic       rd6;
    logic       rd4;
    logic       derr6;
    logic       derr4;
    rx_word_t   dec_word;

    assign rev = sym_reverse(symbol);
    assign g6  = rev[9:4];
    assign g4  = rev[3:0];
    assign k28 = (g6 == 6'b001111) || (g6 == 6'b110000);

    // ==================================================
    // 6b/5b lookup
    // ==================================================
    always_comb begin
        ok6 = 1'b1;
        case (g6)
            6'b100111, 6'b011000: x5 = 5'd0;
            6'b011101, 6'b100010: x5 = 5'd1;
            6'b101101, 6'b010010: x5 = 5'd2;
            6'b110001:            x5 = 5'd3;
            6'b110101, 6'b001010: x5 = 5'd4;
            6'b101001:            x5 = 5'd5;
            6'b011001:            x5 = 5'd6;
            6'b111000, 6'b000111: x5 = 5'd7;
            6'b111001, 6'b000110: x5 = 5'd8;
            6'b100101:            x5 = 5'd9;
            6'b010101:            x5 = 5'd10;
            6'b110100:            x5 = 5'd11;
            6'b001101:            x5 = 5'd12;
            6'b101100:            x5 = 5'd13;
            6'b011100:            x5 = 5'd14;
            6'b010111, 6'b101000: x5 = 5'd15;
            6'b011011, 6'b100100: x5 = 5'd16;
            6'b100011:            x5 = 5'd17;
            6'b010011:            x5 = 5'd18;
            6'b110010:            x5 = 5'd19;
            6'b001011:            x5 = 5'd20;
            6'b101010:            x5 = 5'd21;
            6'b011010:            x5 = 5'd22;
            6'b111010, 6'b000101: x5 = 5'd23;
            6'b110011, 6'b001100: x5 = 5'd24;
            6'b100110:            x5 = 5'd25;
            6'b010110:            x5 = 5'd26;
            6'b110110, 6'b001001: x5 = 5'd27;
            6'b001110:            x5 = 5'd28;         // D.28
            6'b001111, 6'b110000: x5 = 5'd28;         // K.28
            6'b101110, 6'b010001: x5 = 5'd29;
            6'b011110, 6'b100001: x5 = 5'd30;
            6'b101011, 6'b010100: x5 = 5'd31;
            default: begin
                x5  = 5'd0;
                ok6 = 1'b0;                           // Unused pattern
            end
        endcase
    end

    // ==================================================
    // 4b/3b lookup
    // ==================================================
    // After K.28 with positive sign the balanced codes come out inverted
    assign g4_dec = (g6 == 6'b110000) ? ~g4 : g4;

    always_comb begin
        ok4 = 1'b1;
        case (g4_dec)
            4'b1011, 4'b0100:                   y3 = 3'd0;
            4'b1001:                            y3 = 3'd1;
            4'b0101:                            y3 = 3'd2;
            4'b1100, 4'b0011:                   y3 = 3'd3;
            4'b1101, 4'b0010:                   y3 = 3'd4;
            4'b1010:                            y3 = 3'd5;
            4'b0110:                            y3 = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: y3 = 3'd7; // P7 and A7
            default: begin
                y3  = 3'd0;
                ok4 = 1'b0;                           // 0000 or 1111
            end
        endcase
    end

    // K.23/27/29/30 only ever carry A7
    assign k_alt = ((g4 == 4'b0111) || (g4 == 4'b1000)) &&
                   (x5 == 5'd23 || x5 == 5'd27 || x5 == 5'd29 || x5 == 5'd30);

    // ==================================================
    // Disparity tracking
    // ==================================================
    assign ones6 = ones_count(g6);
    assign ones4 = ones_count({2'b00, g4});

    assign rd6 = (ones6 == 3'd3) ? rd : (ones6 > 3'd3); // Follows group sign even on error
    assign rd4 = (ones4 == 3'd2) ? rd6 : (ones4 > 3'd2);

    assign derr6 = ((ones6 == 3'd4) && rd)  || ((ones6 == 3'd2) && !rd) ||
                   ((g6 == 6'b111000) && rd) || ((g6 == 6'b000111) && !rd);
    assign derr4 = ((ones4 == 3'd3) && rd6) || ((ones4 == 3'd1) && !rd6) ||
                   ((g4 == 4'b1100) && rd6) || ((g4 == 4'b0011) && !rd6);

    always_comb begin
        dec_word.code_err = !(ok6 && ok4);
        dec_word.disp_err = derr6 || derr4;
        dec_word.charisk  = k28 || k_alt;
        dec_word.data     = {y3, x5};                 // HGF EDCBA
    end

    // ==================================================
    // Output registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (en) begin
            word <= dec_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd    <= 1'b0;                            // Start negative
            valid <= 1'b0;
        end else begin
            valid <= en;
            if (en) begin
                rd <= rd4;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/enc_8b10b.sv
// 8b/10b encoder
// 5b/6b and 3b/4b tables chosen by running disparity, one symbol per enable
// Flags control requests that are not one of the twelve K codes
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b import line_code_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           en,                         // Encode word this cycle
    input  wire tx_word_t word,
    input  wire           disp_in,                    // 1 = positive running disparity
    output symbol_t       symbol,
    output logic          kerr,                       // Invalid K request
    output logic          disp_out,
    output logic          valid
);

    logic [4:0] x5;                                   // EDCBA
    logic [2:0] y3;                                   // HGF
    logic [5:0] b6_neg;                               // abcdei for negative disparity
    logic [5:0] b6;
    logic [3:0] b4_neg;                               // fghj for negative disparity
    logic [3:0] b4;
    logic       k28;
    logic       k_valid;
    logic       k_sel;
    logic       alt7;
    logic       unbal6;
    logic       unbal4;
    logic       flip6;
    logic       flip4;
    logic       disp_6b;
    logic       disp_4b;

    assign x5 = word.data[4:0];
    assign y3 = word.data[7:5];

    assign k28     = word.charisk && (x5 == 5'd28);
    assign k_valid = (x5 == 5'd28) ||                 // K.28.0 to K.28.7
                     ((y3 == 3'd7) && (x5 == 5'd23 || x5 == 5'd27 ||
                                       x5 == 5'd29 || x5 == 5'd30));
    assign k_sel   = word.charisk && k_valid;         // Bad K falls back to data code

    // ==================================================
    // 5b/6b sub-block
    // ==================================================
    always_comb begin
        case (x5)
            5'd0:    b6_neg = 6'b100111;
            5'd1:    b6_neg = 6'b011101;
            5'd2:    b6_neg = 6'b101101;
            5'd3:    b6_neg = 6'b110001;
            5'd4:    b6_neg = 6'b110101;
            5'd5:    b6_neg = 6'b101001;
            5'd6:    b6_neg = 6'b011001;
            5'd7:    b6_neg = 6'b111000;              // Balanced, still alternates
            5'd8:    b6_neg = 6'b111001;
            5'd9:    b6_neg = 6'b100101;
            5'd10:   b6_neg = 6'b010101;
            5'd11:   b6_neg = 6'b110100;
            5'd12:   b6_neg = 6'b001101;
            5'd13:   b6_neg = 6'b101100;
            5'd14:   b6_neg = 6'b011100;
            5'd15:   b6_neg = 6'b010111;
            5'd16:   b6_neg = 6'b011011;
            5'd17:   b6_neg = 6'b100011;
            5'd18:   b6_neg = 6'b010011;
            5'd19:   b6_neg = 6'b110010;
            5'd20:   b6_neg = 6'b001011;
            5'd21:   b6_neg = 6'b101010;
            5'd22:   b6_neg = 6'b011010;
            5'd23:   b6_neg = 6'b111010;
            5'd24:   b6_neg = 6'b110011;
            5'd25:   b6_neg = 6'b100110;
            5'd26:   b6_neg = 6'b010110;
            5'd27:   b6_neg = 6'b110110;
            5'd28:   b6_neg = k28 ? 6'b001111 : 6'b001110; // K.28 vs D.28
            5'd29:   b6_neg = 6'b101110;
            5'd30:   b6_neg = 6'b011110;
            default: b6_neg = 6'b101011;              // D.31
        endcase
    end

    assign unbal6  = (ones_count(b6_neg) != 3'd3);
    assign flip6   = unbal6 || (x5 == 5'd7);          // Complement under positive RD
    assign b6      = (disp_in && flip6) ? ~b6_neg : b6_neg;
    assign disp_6b = disp_in ^ unbal6;                // Unbalanced group flips RD

    // ==================================================
    // 3b/4b sub-block
    // ==================================================
    // Alternate 7 avoids runs of five on the abcdei/fghj boundary
    assign alt7 = k_sel ||
                  (!disp_6b && (x5 == 5'd17 || x5 == 5'd18 || x5 == 5'd20)) ||
                  (disp_6b  && (x5 == 5'd11 || x5 == 5'd13 || x5 == 5'd14));

    always_comb begin
        case (y3)
            3'd0:    b4_neg = 4'b1011;
            3'd1:    b4_neg = k28 ? 4'b0110 : 4'b1001;
            3'd2:    b4_neg = k28 ? 4'b1010 : 4'b0101;
            3'd3:    b4_neg = 4'b1100;
            3'd4:    b4_neg = 4'b1101;
            3'd5:    b4_neg = k28 ? 4'b0101 : 4'b1010;
            3'd6:    b4_neg = k28 ? 4'b1001 : 4'b0110;
            default: b4_neg = alt7 ? 4'b0111 : 4'b1110; // A7 or P7
        endcase
    end

    assign unbal4  = (y3 == 3'd0) || (y3 == 3'd4) || (y3 == 3'd7);
    assign flip4   = unbal4 || (y3 == 3'd3) || k28;  // K.28 balanced codes alternate too
    assign b4      = (disp_6b && flip4) ? ~b4_neg : b4_neg;
    assign disp_4b = disp_6b ^ unbal4;

    // ==================================================
    // Output registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            symbol   <= RESET_SYMBOL;
            kerr     <= 1'b0;
            disp_out <= 1'b0;                         // Start negative
        end else if (en) begin
            symbol   <= sym_reverse({b6, b4});        // Bit a goes out first
            kerr     <= word.charisk && !k_valid;
            disp_out <= disp_4b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= en;                              // One cycle pulse per word
        end
    end

endmodule

`default_nettype wire

//--- source/line_code_pkg.sv
// 8b/10b link shared definitions
// Widths, word structs, reset symbol and small bit helpers
`default_nettype none

package line_code_pkg;

    localparam int BYTE_W    = 8;                     // Data byte width
    localparam int SYM_W     = 10;                    // Line symbol width
    localparam int ERR_CNT_W = 16;                    // Error counter width

    typedef logic [BYTE_W-1:0]    byte_t;             // Raw data byte
    typedef logic [SYM_W-1:0]     symbol_t;           // Bit a sits at bit 0
    typedef logic [ERR_CNT_W-1:0] err_count_t;        // Errored symbol count

    typedef struct packed {
        logic  charisk;                               // Control character request
        byte_t data;                                  // HGF EDCBA
    } tx_word_t;

    typedef struct packed {
        logic  code_err;                              // Group not in any table
        logic  disp_err;                              // Group sign against running disparity
        logic  charisk;                               // One of the twelve K codes
        byte_t data;                                  // Decoded HGF EDCBA
    } rx_word_t;

    localparam symbol_t    RESET_SYMBOL  = 10'b0101010101; // Alternating, sent in reset
    localparam err_count_t ERR_COUNT_MAX = '1;             // Counter saturates here

    // Swap between abcdeifghj order and line order
    function automatic symbol_t sym_reverse(input symbol_t s);
        symbol_t r;
        for (int i = 0; i < SYM_W; i++) begin
            r[i] = s[SYM_W-1-i];
        end
        return r;
    endfunction

    // Ones in a sub-block, 4b groups are zero padded
    function automatic logic [2:0] ones_count(input logic [5:0] v);
        logic [2:0] n;
        n = '0;
        for (int i = 0; i < 6; i++) begin
            n = n + {2'b00, v[i]};
        end
        return n;
    endfunction

endpackage

`default_nettype wire

//--- source/link_8b10b.sv
// 8b/10b link endpoint
// Encoder and decoder halves with separate symbol ports, plus the
// receive error counter
`timescale 1ns/1ps
`default_nettype none

module link_8b10b import line_code_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    // Transmit side
    input  wire             tx_en,
    input  wire tx_word_t   tx_word,
    output wire symbol_t    tx_symbol,
    output wire             tx_kerr,
    output wire             tx_valid,
    // Receive side
    input  wire             rx_en,
    input  wire symbol_t    rx_symbol,
    output wire rx_word_t   rx_word,
    output wire             rx_valid,
    // Error statistics
    input  wire             err_clear,
    output wire err_count_t err_count
);

    wire tx_disp;                                     // Encoder RD fed back to itself

    enc_8b10b u_enc (
        .clk      (clk),
        .rst      (rst),
        .en       (tx_en),
        .word     (tx_word),
        .disp_in  (tx_disp),
        .symbol   (tx_symbol),
        .kerr     (tx_kerr),
        .disp_out (tx_disp),
        .valid    (tx_valid)
    );

    dec_8b10b u_dec (
        .clk    (clk),
        .rst    (rst),
        .en     (rx_en),
        .symbol (rx_symbol),
        .word   (rx_word),
        .valid  (rx_valid)
    );

    link_err_counter u_err (
        .clk   (clk),
        .rst   (rst),
        .clear (err_clear),
        .valid (rx_valid),
        .word  (rx_word),
        .count (err_count)
    );

endmodule

`default_nettype wire

//--- source/link_err_counter.sv
// Receive error counter
// Counts decoded symbols with a code or disparity error, saturating
`timescale 1ns/1ps
`default_nettype none

module link_err_counter import line_code_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           clear,                      // Wins over an increment
    input  wire           valid,
    input  wire rx_word_t word,
    output err_count_t    count
);

    logic hit;                                        // Errored symbol this cycle
    logic at_max;

    assign hit    = valid && (word.code_err || word.disp_err);
    assign at_max = (count == ERR_COUNT_MAX);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (hit && !at_max) begin
            count <= count + 1'b1;                    // Hold at max
        end
    end

endmodule

`default_nettype wire

//--- test/link_input.txt
# data charisk flip_mask exp_data exp_charisk exp_kerr exp_err, all hex
# exp_data and exp_charisk apply only to lines with exp_err clear
00 0 000 00 0 0 0
b5 0 000 b5 0 0 0
f1 0 000 f1 0 0 0
eb 0 000 eb 0 0 0
2f 0 000 2f 0 0 0
f4 0 000 f4 0 0 0
07 0 000 07 0 0 0
27 0 000 27 0 0 0
63 0 000 63 0 0 0
ff 0 000 ff 0 0 0
ed 0 000 ed 0 0 0
92 0 000 92 0 0 0
c8 0 000 c8 0 0 0
ee 0 000 ee 0 0 0
ee 0 000 ee 0 0 0
1c 1 000 1c 1 0 0
3c 1 000 3c 1 0 0
5c 1 000 5c 1 0 0
7c 1 000 7c 1 0 0
9c 1 000 9c 1 0 0
bc 1 000 bc 1 0 0
dc 1 000 dc 1 0 0
fc 1 000 fc 1 0 0
f7 1 000 f7 1 0 0
fb 1 000 fb 1 0 0
fd 1 000 fd 1 0 0
fe 1 000 fe 1 0 0
00 1 000 00 0 1 0
37 0 018 37 0 0 1
b5 0 000 b5 0 0 0
b5 0 001 b5 0 0 1
2f 0 000 2f 0 0 0
15 0 080 15 0 0 1
00 0 000 00 0 0 0

//--- test/tb_link_8b10b.sv
// Testbench for the 8b/10b link endpoint
// Reads vectors from a text file, loops each transmit symbol back to the
// receive port with an optional bit flip mask, checks decoded words,
// flags and the receive error counter
`timescale 1ns/1ps
`default_nettype none

module tb_link_8b10b import line_code_pkg::*; ();

    localparam int WAIT_LIMIT = 20;                   // Cycles before a wait gives up

    logic       clk = 1'b0;
    logic       rst;
    logic       tx_en;
    tx_word_t   tx_word;
    symbol_t    tx_symbol;
    logic       tx_kerr;
    logic       tx_valid;
    logic       rx_en;
    symbol_t    rx_symbol;
    rx_word_t   rx_word;
    logic       rx_valid;
    logic       err_clear;
    err_count_t err_count;

    int fails;                                        // Mismatches so far
    int tests_passed;
    int tests_failed;
    int exp_err_total;                                // Lines expecting an error flag
    bit timed_out;

    link_8b10b u_link_8b10b (
        .clk       (clk),
        .rst       (rst),
        .tx_en     (tx_en),
        .tx_word   (tx_word),
        .tx_symbol (tx_symbol),
        .tx_kerr   (tx_kerr),
        .tx_valid  (tx_valid),
        .rx_en     (rx_en),
        .rx_symbol (rx_symbol),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .err_clear (err_clear),
        .err_count (err_count)
    );

    always #2 clk = ~clk;                             // 4 ns period

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            fails++;
        end
    endtask

    task automatic close_test(input string name, input int fails_before);
        if (fails == fails_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    // Polls a valid strobe on falling edges until it rises or the limit runs out
    task automatic wait_valid(input bit rx_side, output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!(rx_side ? rx_valid : tx_valid) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = rx_side ? rx_valid : tx_valid;
        if (!ok) begin
            $display("timeout: %s did not rise within %0d cycles",
                     rx_side ? "rx_valid" : "tx_valid", WAIT_LIMIT);
            fails++;
            timed_out = 1'b1;
        end
    endtask

    // ==================================================
    // One vector through encoder, flip mask and decoder
    // ==================================================
    task automatic run_vector(input int idx, input byte_t data, input logic k,
                              input symbol_t mask, input byte_t exp_data,
                              input logic exp_k, input logic exp_kerr, input logic exp_err);
        int       gap;
        int       fails_before;
        bit       ok;
        symbol_t  sent;
        logic     kerr_seen;
        rx_word_t got;
        string    name;
        fails_before = fails;
        name = $sformatf("vector %0d byte %h k %b mask %h", idx, data, k, mask);
        gap = $urandom % 4;                           // Idle cycles between symbols
        repeat (gap) @(posedge clk);
        @(posedge clk);
        tx_en   <= 1'b1;
        tx_word <= {k, data};
        @(posedge clk);
        tx_en <= 1'b0;
        wait_valid(1'b0, ok);
        if (ok) begin
            sent      = tx_symbol;
            kerr_seen = tx_kerr;
            @(posedge clk);
            rx_en     <= 1'b1;
            rx_symbol <= sent ^ mask;                 // Line corruption
            @(posedge clk);
            rx_en <= 1'b0;
            wait_valid(1'b1, ok);
            if (ok) begin
                got = rx_word;
                check_value(kerr_seen, exp_kerr, "tx_kerr");
                check_value(got.code_err | got.disp_err, exp_err, "error flag");
                if (!exp_err) begin                   // Content of a bad symbol is undefined
                    check_value(got.data, exp_data, "decoded byte");
                    check_value(got.charisk, exp_k, "decoded charisk");
                end
            end
        end
        close_test(name, fails_before);
    endtask

    initial begin
        int              fd;
        int              got_chars;
        int              n_fields;
        int              idx;
        int              fails_before;
        int              seed_ret;
        logic [8*96-1:0] line;
        logic [15:0]     f_data;
        logic [15:0]     f_k;
        logic [15:0]     f_mask;
        logic [15:0]     f_exp_data;
        logic [15:0]     f_exp_k;
        logic [15:0]     f_exp_kerr;
        logic [15:0]     f_exp_err;
        seed_ret      = $urandom(59333);
        rst           = 1'b1;
        tx_en         = 1'b0;
        tx_word       = '0;
        rx_en         = 1'b0;
        rx_symbol     = '0;
        err_clear     = 1'b0;
        fails         = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        exp_err_total = 0;
        timed_out     = 1'b0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fails_before = fails;
        @(negedge clk);
        check_value(tx_valid, 1'b0, "tx_valid after reset");
        check_value(rx_valid, 1'b0, "rx_valid after reset");
        check_value(tx_kerr, 1'b0, "tx_kerr after reset");
        check_value(tx_symbol, RESET_SYMBOL, "tx_symbol after reset");
        check_value(err_count, 0, "err_count after reset");
        close_test("reset state", fails_before);

        // ==================================================
        // Vector file
        // ==================================================
        fd = $fopen("test/link_input.txt", "r");
        if (fd == 0) begin
            $display("could not open test/link_input.txt");
            fails++;
            tests_failed++;
        end else begin
            idx = 0;
            while (!$feof(fd) && !timed_out) begin
                line      = '0;
                got_chars = $fgets(line, fd);
                n_fields  = 0;
                if (got_chars > 0) begin
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h", f_data, f_k, f_mask,
                                       f_exp_data, f_exp_k, f_exp_kerr, f_exp_err);
                end
                if (n_fields == 7) begin              // Comment and blank lines skipped
                    if (f_exp_err[0]) begin
                        exp_err_total++;
                    end
                    run_vector(idx, f_data[7:0], f_k[0], f_mask[9:0], f_exp_data[7:0],
                               f_exp_k[0], f_exp_kerr[0], f_exp_err[0]);
                    idx++;
                end
            end
            $fclose(fd);
            if (idx == 0) begin
                $display("no vectors found in test/link_input.txt");
                fails++;
                tests_failed++;
            end
            if (!timed_out) begin
                fails_before = fails;
                @(posedge clk);                       // Counter lags rx_valid by one cycle
                @(negedge clk);
                check_value(err_count, exp_err_total, "err_count after vectors");
                close_test("error count", fails_before);
                fails_before = fails;
                @(posedge clk);
                err_clear <= 1'b1;
                @(posedge clk);
                err_clear <= 1'b0;
                @(negedge clk);
                check_value(err_count, 0, "err_count after clear");
                close_test("error clear", fails_before);
            end
        end

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
